//--- files.f
+incdir+src
src/memctl_pkg.sv
src/spi_master.sv
src/lane_align.sv
src/access_arbiter.sv
src/mem_ctl.sv
test/spi_mem_model.sv
test/mem_ctl_checker.sv
test/mem_ctl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mem_ctl_tb \
    -f files.f -o mem_ctl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mem_ctl_sim +verilator+error+limit+100)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

//--- test/mem_ctl_tb.sv
// Testbench for the SPI memory controller with LFSR flash preload and shadow memory
// Stimulus table with expected values, check task and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "memctl_config.svh"

module mem_ctl_tb;

    localparam int NUM_ENTRIES     = 23;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 200;
    localparam int WAIT_LIMIT      = 400;
    localparam int MEM_BYTES       = 8192;

    localparam int K_FETCH      = 0;
    localparam int K_LOAD       = 1;
    localparam int K_STORE      = 2;
    localparam int K_GPIO_WR    = 3;
    localparam int K_GPIO_RD    = 4;
    localparam int K_FETCH_LOAD = 5;

    logic                          clk;
    logic                          rst_n;
    logic [31:0]                   instr_addr;
    logic [31:0]                   instr_data;
    logic                          instr_ready;
    logic [31:0]                   mem_addr;
    logic [31:0]                   mem_wdata;
    logic [2:0]                    mem_flag;
    logic                          mem_we;
    logic                          mem_re;
    logic [31:0]                   mem_rdata;
    logic                          mem_ready;
    logic [`MEMCTL_GPIO_WIDTH-1:0] gpio_out;
    logic                          flash_cs_n;
    logic                          ram_cs_n;
    logic                          spi_sclk;
    logic                          spi_mosi;
    logic                          spi_miso;

    // Stimulus table and expected results
    int          kind_tab      [NUM_ENTRIES];
    logic [31:0] addr_tab      [NUM_ENTRIES];
    logic [2:0]  f3_tab        [NUM_ENTRIES];
    logic [31:0] wdata_tab     [NUM_ENTRIES];
    logic [31:0] iaddr_tab     [NUM_ENTRIES];
    logic [31:0] exp_tab       [NUM_ENTRIES];
    logic [31:0] exp_instr_tab [NUM_ENTRIES];

    logic [7:0] shadow_flash [MEM_BYTES];
    logic [7:0] shadow_ram   [MEM_BYTES];

    int errors;
    int checks;

    mem_ctl u_mem_ctl (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_flag    (mem_flag),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .gpio_out    (gpio_out),
        .flash_cs_n  (flash_cs_n),
        .ram_cs_n    (ram_cs_n),
        .spi_sclk    (spi_sclk),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso)
    );

    spi_mem_model u_mem (
        .sclk       (spi_sclk),
        .mosi       (spi_mosi),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .miso       (spi_miso)
    );

    always #5 clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] addr);
        if (addr < `MEMCTL_FLASH_SIZE) begin
            return shadow_flash[addr[12:0]];
        end
        return shadow_ram[addr[12:0]];
    endfunction

    // Little-endian word, narrow loads zero-extended
    function automatic logic [31:0] expect_load(input logic [31:0] addr, input logic [2:0] f3);
        logic [31:0] word;
        word = {shadow_byte(addr + 32'd3), shadow_byte(addr + 32'd2),
                shadow_byte(addr + 32'd1), shadow_byte(addr)};
        case (f3)
            3'b000, 3'b100: return {24'h0, word[7:0]};
            3'b001, 3'b101: return {16'h0, word[15:0]};
            default:        return word;
        endcase
    endfunction

    task automatic shadow_store(input logic [31:0] addr, input logic [2:0] f3,
                                input logic [31:0] wdata);
        int          nbytes;
        logic [31:0] byte_addr;
        nbytes = (f3 == 3'b000) ? 1 : (f3 == 3'b001) ? 2 : 4;
        for (int k = 0; k < nbytes; k++) begin
            byte_addr = addr + 32'(k);
            if (byte_addr < `MEMCTL_FLASH_SIZE) begin
                shadow_flash[byte_addr[12:0]] = wdata[8*k +: 8];
            end else begin
                shadow_ram[byte_addr[12:0]] = wdata[8*k +: 8];
            end
        end
    endtask

    // Flash from the LFSR, one step per bit; RAM from an address pattern
    task automatic preload_memories();
        logic [31:0] state;
        logic [7:0]  value;
        state = 32'd70310;
        for (int i = 0; i < MEM_BYTES; i++) begin
            value = 8'h00;
            for (int b = 0; b < 8; b++) begin
                value = {value[6:0], state[0]};
                state = lfsr_step(state);
            end
            shadow_flash[i]    = value;
            u_mem.flash_mem[i] = value;
            value              = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
            shadow_ram[i]      = value;
            u_mem.ram_mem[i]   = value;
        end
    endtask

    task automatic set_entry(input int idx, input int kind, input logic [31:0] addr,
                             input logic [2:0] f3, input logic [31:0] wdata,
                             input logic [31:0] iaddr);
        kind_tab[idx]  = kind;
        addr_tab[idx]  = addr;
        f3_tab[idx]    = f3;
        wdata_tab[idx] = wdata;
        iaddr_tab[idx] = iaddr;
    endtask

    task automatic build_table();
        set_entry(0,  K_FETCH,      32'h0000_0000, 3'd2, 32'h0,         32'h0);
        set_entry(1,  K_FETCH,      32'h0000_0004, 3'd2, 32'h0,         32'h0);
        set_entry(2,  K_FETCH,      32'h0000_0110, 3'd2, 32'h0,         32'h0);
        set_entry(3,  K_STORE,      32'h0000_2100, 3'd2, 32'hDEAD_BEEF, 32'h0);
        set_entry(4,  K_LOAD,       32'h0000_2100, 3'd2, 32'h0,         32'h0);
        // Narrow stores carry junk in the unused bytes
        set_entry(5,  K_STORE,      32'h0000_2102, 3'd0, 32'hA5A5_55A5, 32'h0);
        set_entry(6,  K_STORE,      32'h0000_2104, 3'd2, 32'h1234_5678, 32'h0);
        set_entry(7,  K_STORE,      32'h0000_2104, 3'd1, 32'h9988_CAFE, 32'h0);
        set_entry(8,  K_LOAD,       32'h0000_2100, 3'd2, 32'h0,         32'h0);
        set_entry(9,  K_LOAD,       32'h0000_2102, 3'd4, 32'h0,         32'h0);
        set_entry(10, K_LOAD,       32'h0000_2103, 3'd0, 32'h0,         32'h0);
        set_entry(11, K_LOAD,       32'h0000_2104, 3'd2, 32'h0,         32'h0);
        // Halfword with its top bit set
        set_entry(12, K_LOAD,       32'h0000_2104, 3'd1, 32'h0,         32'h0);
        set_entry(13, K_LOAD,       32'h0000_0040, 3'd2, 32'h0,         32'h0);
        set_entry(14, K_LOAD,       32'h0000_0123, 3'd0, 32'h0,         32'h0);
        set_entry(15, K_LOAD,       32'h0000_0222, 3'd1, 32'h0,         32'h0);
        set_entry(16, K_GPIO_WR,    `MEMCTL_GPIO_ADDR, 3'd2, 32'hFFFF_FFF6, 32'h0);
        set_entry(17, K_GPIO_RD,    `MEMCTL_GPIO_ADDR, 3'd2, 32'h0,     32'h0);
        set_entry(18, K_FETCH_LOAD, 32'h0000_2100, 3'd2, 32'h0,         32'h0000_0200);
        set_entry(19, K_GPIO_WR,    `MEMCTL_GPIO_ADDR, 3'd2, 32'h0000_0009, 32'h0);
        set_entry(20, K_GPIO_RD,    `MEMCTL_GPIO_ADDR, 3'd2, 32'h0,     32'h0);
        set_entry(21, K_STORE,      32'h0000_3FFC, 3'd2, 32'hA5C3_0F1E, 32'h0);
        // funct3 of 6 is unknown and reads a full word
        set_entry(22, K_LOAD,       32'h0000_3FFC, 3'd6, 32'h0,         32'h0);
    endtask

    // Walk the table once against the shadow memory
    task automatic predict_table();
        logic [31:0] gpio_model;
        gpio_model = 32'h0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            exp_tab[i]       = 32'h0;
            exp_instr_tab[i] = 32'h0;
            case (kind_tab[i])
                K_FETCH:   exp_tab[i] = expect_load(addr_tab[i], 3'b010);
                K_LOAD:    exp_tab[i] = expect_load(addr_tab[i], f3_tab[i]);
                K_STORE:   shadow_store(addr_tab[i], f3_tab[i], wdata_tab[i]);
                K_GPIO_WR: begin
                    gpio_model = wdata_tab[i] & ((32'd1 << `MEMCTL_GPIO_WIDTH) - 32'd1);
                    exp_tab[i] = gpio_model;
                end
                K_GPIO_RD: exp_tab[i] = gpio_model;
                K_FETCH_LOAD: begin
                    exp_tab[i]       = expect_load(addr_tab[i], f3_tab[i]);
                    exp_instr_tab[i] = expect_load(iaddr_tab[i], 3'b010);
                end
                default: ;
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
        end
    endtask

    // One-cycle request pulse, then wait for mem_ready
    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [2:0] f3, input logic [31:0] wdata);
        int cycles;
        mem_addr  = addr;
        mem_flag  = f3;
        mem_wdata = wdata;
        mem_we    = we;
        mem_re    = !we;
        @(negedge clk);
        mem_we = 1'b0;
        mem_re = 1'b0;
        cycles = 0;
        while (!mem_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!mem_ready) begin
            errors++;
            $display("Error at %0d ns: no mem_ready for the access to 0x%08h", $time, addr);
        end
    endtask

    task automatic wait_instr();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!instr_ready && cycles < WAIT_LIMIT);
        if (!instr_ready) begin
            errors++;
            $display("Error at %0d ns: instr_ready never rose for 0x%08h", $time, instr_addr);
        end
    endtask

    task automatic apply_entry(input int i);
        case (kind_tab[i])
            K_FETCH: begin
                instr_addr = addr_tab[i];
                wait_instr();
                check_value("instr_data", instr_data, exp_tab[i]);
            end
            K_LOAD, K_GPIO_RD: begin
                data_access(1'b0, addr_tab[i], f3_tab[i], 32'h0);
                check_value("mem_rdata", mem_rdata, exp_tab[i]);
            end
            K_STORE: data_access(1'b1, addr_tab[i], f3_tab[i], wdata_tab[i]);
            K_GPIO_WR: begin
                data_access(1'b1, addr_tab[i], f3_tab[i], wdata_tab[i]);
                check_value("gpio_out", 32'(gpio_out), exp_tab[i]);
            end
            K_FETCH_LOAD: begin
                // Let the fetch get under way before the load cuts in
                instr_addr = iaddr_tab[i];
                repeat (12) @(negedge clk);
                check_value("instr_ready", 32'(instr_ready), 32'h0);
                data_access(1'b0, addr_tab[i], f3_tab[i], 32'h0);
                check_value("mem_rdata", mem_rdata, exp_tab[i]);
                wait_instr();
                check_value("instr_data", instr_data, exp_instr_tab[i]);
            end
            default: ;
        endcase
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not finish",
                 WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr_addr = 32'h0;
        mem_addr   = 32'h0;
        mem_wdata  = 32'h0;
        mem_flag   = 3'b010;
        mem_we     = 1'b0;
        mem_re     = 1'b0;
        errors     = 0;
        checks     = 0;
        preload_memories();
        build_table();
        predict_table();

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(negedge clk);
            apply_entry(i);
        end
        repeat (4) @(negedge clk);

        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, u_mem_ctl.u_checker.assert_fails);
        if (errors == 0 && u_mem_ctl.u_checker.assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mem_ctl_checker.sv
// Bound assertions on the chip selects, sclk idle level and mem_ready pulse
`timescale 1ns/1ps
`default_nettype none

module mem_ctl_checker (
    input logic clk,
    input logic rst_n,
    input logic flash_cs_n,
    input logic ram_cs_n,
    input logic spi_sclk,
    input logic mem_ready
);

    // Failure count, read by the testbench summary
    int assert_fails = 0;

    // Never both low, and a device is selected only after a cycle with the other one high
    one_device: assert property (@(posedge clk) disable iff (!rst_n)
        (flash_cs_n || ram_cs_n) && (flash_cs_n || $past(ram_cs_n))
        && (ram_cs_n || $past(flash_cs_n)))
        else begin
            assert_fails++;
            $error("flash and RAM chip selects overlap or switch without a deselect gap");
        end

    ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready)
        else begin
            assert_fails++;
            $error("mem_ready stayed high for two cycles");
        end

    sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (flash_cs_n && ram_cs_n) |-> !spi_sclk)
        else begin
            assert_fails++;
            $error("sclk is high with no device selected");
        end

endmodule

bind mem_ctl mem_ctl_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .flash_cs_n (flash_cs_n),
    .ram_cs_n   (ram_cs_n),
    .spi_sclk   (spi_sclk),
    .mem_ready  (mem_ready)
);

`default_nettype wire

//--- test/spi_mem_model.sv
// Behavioral serial flash and RAM sharing one SPI bus
// Mode 0, read and write commands with a 24-bit address
`timescale 1ns/1ps
`default_nettype none

`include "memctl_config.svh"

module spi_mem_model (
    input  logic sclk,
    input  logic mosi,
    input  logic flash_cs_n,
    input  logic ram_cs_n,
    output logic miso
);

    localparam int MEM_BYTES = 8192;

    logic [7:0]  flash_mem [MEM_BYTES];
    logic [7:0]  ram_mem   [MEM_BYTES];
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [7:0]  wbyte;
    logic        deselect;
    logic        miso_q = 1'b0;
    int          bit_cnt = 0;
    int          wr_idx;
    int          rd_idx;

    assign deselect = flash_cs_n && ram_cs_n;
    assign miso     = miso_q;

    // Command, address and write data are taken on rising sclk
    always @(posedge sclk or posedge deselect) begin
        if (deselect) begin
            bit_cnt = 0;
        end else begin
            if (bit_cnt < 8) begin
                cmd = {cmd[6:0], mosi};
            end else if (bit_cnt < 32) begin
                addr = {addr[22:0], mosi};
            end else begin
                wbyte = {wbyte[6:0], mosi};
                // Byte complete, address counts up
                if (cmd == `MEMCTL_CMD_WRITE && (bit_cnt - 32) % 8 == 7) begin
                    wr_idx = (int'(addr[12:0]) + (bit_cnt - 32) / 8) % MEM_BYTES;
                    if (!flash_cs_n) begin
                        flash_mem[wr_idx] = wbyte;
                    end else begin
                        ram_mem[wr_idx] = wbyte;
                    end
                end
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    // Read data leaves on falling sclk, lowest address first, MSB first
    always @(negedge sclk) begin
        if (!deselect && bit_cnt >= 32) begin
            rd_idx = (int'(addr[12:0]) + (bit_cnt - 32) / 8) % MEM_BYTES;
            if (!flash_cs_n) begin
                miso_q <= flash_mem[rd_idx][7 - (bit_cnt - 32) % 8];
            end else begin
                miso_q <= ram_mem[rd_idx][7 - (bit_cnt - 32) % 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/mem_ctl.sv
// Memory controller top level for flash and RAM on one SPI bus
// Arbiter, lane aligner and SPI engine, chip select fan-out
`timescale 1ns/1ps
`default_nettype none

`include "memctl_config.svh"

module mem_ctl
    import memctl_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [31:0]                   instr_addr,
    output logic [31:0]                   instr_data,
    output logic                          instr_ready,
    input  logic [31:0]                   mem_addr,
    input  logic [31:0]                   mem_wdata,
    input  logic [2:0]                    mem_flag,
    input  logic                          mem_we,
    input  logic                          mem_re,
    output logic [31:0]                   mem_rdata,
    output logic                          mem_ready,
    output logic [`MEMCTL_GPIO_WIDTH-1:0] gpio_out,
    output logic                          flash_cs_n,
    output logic                          ram_cs_n,
    output logic                          spi_sclk,
    output logic                          spi_mosi,
    input  logic                          spi_miso
);

    logic                             spi_start;
    logic                             spi_abort;
    logic [7:0]                       spi_cmd;
    logic [`MEMCTL_SPI_ADDR_BITS-1:0] spi_addr;
    logic [5:0]                       spi_len;
    spi_word_u                        spi_wdata;
    spi_word_u                        spi_rdata;
    logic                             spi_done;
    logic                             spi_cs_n;
    logic                             spi_route_flash;
    spi_word_u                        wire_wdata;
    logic [5:0]                       data_len;
    logic [31:0]                      load_data;
    logic [31:0]                      instr_word;

    // One engine chip select, steered by the latched region
    assign flash_cs_n = spi_route_flash ? spi_cs_n : 1'b1;
    assign ram_cs_n   = spi_route_flash ? 1'b1 : spi_cs_n;

    access_arbiter u_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr_addr      (instr_addr),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_we          (mem_we),
        .mem_re          (mem_re),
        .load_data       (load_data),
        .instr_word      (instr_word),
        .wire_wdata      (wire_wdata),
        .data_len        (data_len),
        .spi_done        (spi_done),
        .instr_data      (instr_data),
        .instr_ready     (instr_ready),
        .mem_rdata       (mem_rdata),
        .mem_ready       (mem_ready),
        .gpio_out        (gpio_out),
        .spi_start       (spi_start),
        .spi_abort       (spi_abort),
        .spi_cmd         (spi_cmd),
        .spi_addr        (spi_addr),
        .spi_len         (spi_len),
        .spi_wdata       (spi_wdata),
        .spi_route_flash (spi_route_flash)
    );

    lane_align u_lane_align (
        .mem_flag   (mem_flag),
        .mem_wdata  (mem_wdata),
        .raw        (spi_rdata),
        .wire_wdata (wire_wdata),
        .data_len   (data_len),
        .load_data  (load_data),
        .instr_word (instr_word)
    );

    spi_master u_spi_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (spi_start),
        .abort    (spi_abort),
        .cmd      (spi_cmd),
        .addr     (spi_addr),
        .data_len (spi_len),
        .wdata    (spi_wdata),
        .miso     (spi_miso),
        .rdata    (spi_rdata),
        .done     (spi_done),
        .sclk     (spi_sclk),
        .cs_n     (spi_cs_n),
        .mosi     (spi_mosi)
    );

endmodule

`default_nettype wire

//--- src/access_arbiter.sv
// Access FSM for the shared SPI bus: data over fetch, fetch abort,
// region select and the local GPIO register
`timescale 1ns/1ps
`default_nettype none

`include "memctl_config.svh"

module access_arbiter
    import memctl_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [31:0]                       instr_addr,
    input  logic [31:0]                       mem_addr,
    input  logic [31:0]                       mem_wdata,
    input  logic                              mem_we,
    input  logic                              mem_re,
    input  logic [31:0]                       load_data,
    input  logic [31:0]                       instr_word,
    input  spi_word_u                         wire_wdata,
    input  logic [5:0]                        data_len,
    input  logic                              spi_done,
    output logic [31:0]                       instr_data,
    output logic                              instr_ready,
    output logic [31:0]                       mem_rdata,
    output logic                              mem_ready,
    output logic [`MEMCTL_GPIO_WIDTH-1:0]     gpio_out,
    output logic                              spi_start,
    output logic                              spi_abort,
    output logic [7:0]                        spi_cmd,
    output logic [`MEMCTL_SPI_ADDR_BITS-1:0]  spi_addr,
    output logic [5:0]                        spi_len,
    output spi_word_u                         spi_wdata,
    output logic                              spi_route_flash
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACTIVE = 2'd1;
    localparam logic [1:0] ST_STOP   = 2'd2;

    logic [1:0]  state;
    logic        data_pend;
    logic        pend_we;
    logic        is_fetch;
    logic        instr_valid;
    logic [31:0] fetch_addr;

    logic data_pulse;
    logic gpio_hit;
    logic spi_pulse;
    logic data_req;
    logic req_we;
    logic fetch_hit;
    logic start_data;
    logic start_fetch;
    logic abort_now;
    logic fetch_done;
    logic data_done;

    assign data_pulse = mem_re || mem_we;
    assign gpio_hit   = (mem_addr == `MEMCTL_GPIO_ADDR);
    assign spi_pulse  = data_pulse && !gpio_hit;

    // The request pulse lasts one cycle, so it is held in data_pend
    assign data_req = spi_pulse || data_pend;
    assign req_we   = data_pend ? pend_we : mem_we;

    // Drops as soon as the core moves to another address
    assign fetch_hit   = instr_valid && (instr_addr == fetch_addr);
    assign instr_ready = fetch_hit;

    assign start_data  = (state == ST_IDLE) && data_req;
    assign start_fetch = (state == ST_IDLE) && !data_req && !fetch_hit;
    assign abort_now   = (state == ST_ACTIVE) && is_fetch && spi_pulse;
    assign fetch_done  = (state == ST_ACTIVE) && is_fetch && spi_done && !abort_now;
    assign data_done   = (state == ST_ACTIVE) && !is_fetch && spi_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            data_pend       <= 1'b0;
            pend_we         <= 1'b0;
            is_fetch        <= 1'b0;
            instr_valid     <= 1'b0;
            mem_ready       <= 1'b0;
            spi_start       <= 1'b0;
            spi_abort       <= 1'b0;
            spi_route_flash <= 1'b1;
            gpio_out        <= '0;
        end else begin
            spi_start <= 1'b0;
            spi_abort <= 1'b0;
            mem_ready <= 1'b0;

            // GPIO is answered locally, a running fetch goes on
            if (data_pulse && gpio_hit) begin
                mem_ready <= 1'b1;
                if (mem_we) begin
                    gpio_out <= mem_wdata[`MEMCTL_GPIO_WIDTH-1:0];
                end
            end

            if (spi_pulse) begin
                data_pend <= 1'b1;
                pend_we   <= mem_we;
            end

            case (state)
                ST_IDLE: begin
                    if (start_data) begin
                        spi_start       <= 1'b1;
                        is_fetch        <= 1'b0;
                        // Constant data may live in flash
                        spi_route_flash <= (mem_addr < `MEMCTL_FLASH_SIZE);
                        state           <= ST_ACTIVE;
                    end else if (start_fetch) begin
                        spi_start       <= 1'b1;
                        is_fetch        <= 1'b1;
                        instr_valid     <= 1'b0;
                        spi_route_flash <= 1'b1;
                        state           <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (abort_now) begin
                        spi_abort <= 1'b1;
                        state     <= ST_STOP;
                    end else if (fetch_done) begin
                        instr_valid <= 1'b1;
                        state       <= ST_IDLE;
                    end else if (data_done) begin
                        mem_ready <= 1'b1;
                        data_pend <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                // Chip select goes high here before the route may change
                ST_STOP: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Transfer setup and returned data
    always_ff @(posedge clk) begin
        if (start_data) begin
            spi_cmd   <= req_we ? `MEMCTL_CMD_WRITE : `MEMCTL_CMD_READ;
            spi_addr  <= mem_addr[`MEMCTL_SPI_ADDR_BITS-1:0];
            spi_len   <= data_len;
            spi_wdata <= wire_wdata;
        end else if (start_fetch) begin
            spi_cmd    <= `MEMCTL_CMD_READ;
            spi_addr   <= instr_addr[`MEMCTL_SPI_ADDR_BITS-1:0];
            spi_len    <= 6'd32;
            spi_wdata  <= '0;
            fetch_addr <= instr_addr;
        end

        if (fetch_done) begin
            instr_data <= instr_word;
        end

        if (data_done && !pend_we) begin
            mem_rdata <= load_data;
        end else if (data_pulse && gpio_hit && !mem_we) begin
            mem_rdata <= {{(32-`MEMCTL_GPIO_WIDTH){1'b0}}, gpio_out};
        end
    end

endmodule

`default_nettype wire

//--- src/lane_align.sv
// Byte lane alignment between core words and SPI wire order
// Also picks the transfer length from funct3
`timescale 1ns/1ps
`default_nettype none

module lane_align
    import memctl_pkg::*;
(
    input  logic [2:0]  mem_flag,
    input  logic [31:0] mem_wdata,
    input  spi_word_u   raw,
    output spi_word_u   wire_wdata,
    output logic [5:0]  data_len,
    output logic [31:0] load_data,
    output logic [31:0] instr_word
);

    // Unknown funct3 values fall back to a word
    always_comb begin
        case (mem_flag)
            3'b000, 3'b100: data_len = 6'd8;
            3'b001, 3'b101: data_len = 6'd16;
            default:        data_len = 6'd32;
        endcase
    end

    // Lowest address byte goes out first
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wire_wdata.bytes[3-i] = mem_wdata[8*i +: 8];
        end
    end

    // Received bytes sit right-aligned, first byte highest
    assign instr_word = {raw.bytes[0], raw.bytes[1], raw.bytes[2], raw.bytes[3]};

    // Narrow loads are zero-extended, signed or not
    always_comb begin
        case (data_len)
            6'd8:    load_data = {24'h0, raw.bytes[0]};
            6'd16:   load_data = {16'h0, raw.bytes[0], raw.bytes[1]};
            default: load_data = instr_word;
        endcase
    end

endmodule

`default_nettype wire

//--- src/spi_master.sv
// Single-bit SPI mode-0 engine
// Sends command, address and a variable length data field, samples miso
`timescale 1ns/1ps
`default_nettype none

`include "memctl_config.svh"

module spi_master
    import memctl_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic                             abort,
    input  logic [7:0]                       cmd,
    input  logic [`MEMCTL_SPI_ADDR_BITS-1:0] addr,
    input  logic [5:0]                       data_len,
    input  spi_word_u                        wdata,
    input  logic                             miso,
    output spi_word_u                        rdata,
    output logic                             done,
    output logic                             sclk,
    output logic                             cs_n,
    output logic                             mosi
);

    localparam int FRAME_BITS = 8 + `MEMCTL_SPI_ADDR_BITS + 32;
    localparam int HDR_BITS   = 8 + `MEMCTL_SPI_ADDR_BITS;

    logic [FRAME_BITS-1:0] shreg;
    logic [5:0]            bit_cnt;
    logic                  busy;
    logic                  phase;
    logic                  launch;

    assign launch = start && !busy;

    // Bit under the low half of sclk
    assign mosi = busy ? shreg[FRAME_BITS-1] : 1'b0;

    // High half of the last bit; rdata already holds it
    assign done = busy && phase && (bit_cnt == 6'd0) && !abort;

    // Frame control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            phase   <= 1'b0;
            sclk    <= 1'b0;
            cs_n    <= 1'b1;
            bit_cnt <= 6'd0;
        end else if (abort) begin
            // Drop the frame at once, no done
            busy  <= 1'b0;
            phase <= 1'b0;
            sclk  <= 1'b0;
            cs_n  <= 1'b1;
        end else if (launch) begin
            busy    <= 1'b1;
            phase   <= 1'b0;
            sclk    <= 1'b0;
            cs_n    <= 1'b0;
            bit_cnt <= data_len + 6'(HDR_BITS - 1);
        end else if (busy) begin
            if (!phase) begin
                // Rising edge, slave and master sample
                sclk  <= 1'b1;
                phase <= 1'b1;
            end else begin
                sclk  <= 1'b0;
                phase <= 1'b0;
                if (bit_cnt == 6'd0) begin
                    busy <= 1'b0;
                    cs_n <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt - 6'd1;
                end
            end
        end
    end

    // Shift registers
    always_ff @(posedge clk) begin
        if (launch) begin
            shreg      <= {cmd, addr, wdata.word};
            rdata.word <= '0;
        end else if (busy) begin
            if (!phase) begin
                // Received bits collect right-aligned
                rdata.word <= {rdata.word[30:0], miso};
            end else begin
                shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- src/memctl_pkg.sv
// Shared types for the memory controller
// SPI shift word seen as one word or as four wire bytes
`default_nettype none

package memctl_pkg;

    // Top byte leaves first on the wire
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } spi_word_u;

endpackage

`default_nettype wire

//--- src/memctl_config.svh
// Memory map, GPIO width and SPI command codes for the memory controller
// Shared by the SPI engine, the access arbiter and the top level
`ifndef MEMCTL_CONFIG_SVH
`define MEMCTL_CONFIG_SVH

// Addresses below this go to flash, the rest to RAM
`define MEMCTL_FLASH_SIZE    32'h0000_2000

// Single GPIO output register
`define MEMCTL_GPIO_ADDR     32'h4000_1000
`define MEMCTL_GPIO_WIDTH    5

// Serial memory commands, same codes for flash and RAM
`define MEMCTL_CMD_READ      8'h03
`define MEMCTL_CMD_WRITE     8'h02

// Address bits sent after the command byte
`define MEMCTL_SPI_ADDR_BITS 24

`endif
